// File: source/refill_pkg.sv
// shared types and line geometry for the data cache refill path, imported by every RTL module
package refill_pkg;

    localparam int line_words = 16; // 32-bit beats per cache line
    localparam int line_bits = 512;

    typedef enum logic {
        op_read = 1'b0,
        op_write = 1'b1
    } op_kind;

    // store widths are encoded as the byte mask of a naturally aligned access
    typedef enum logic [3:0] {
        width_byte = 4'b0001,
        width_half = 4'b0011,
        width_word = 4'b1111
    } store_width;

    typedef enum logic {
        miss_idle = 1'b0,
        miss_wait = 1'b1
    } miss_state;

endpackage

// File: source/miss_request_reg.sv
// holds the single outstanding miss, from its strobe until the refill finishes
module miss_request_reg
    import refill_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        miss_valid,
    input  logic [31:0] miss_addr,
    input  op_kind      miss_op,
    input  store_width  miss_width,
    input  logic        miss_uncached,
    input  logic [31:0] miss_store_data,
    input  logic        fill_finish,
    output logic [31:0] req_addr,
    output op_kind      req_op,
    output store_width  req_width,
    output logic        req_uncached,
    output logic [31:0] req_store_data,
    output logic        busy
);

    miss_state state;
    logic      accept;

    assign accept = miss_valid && (state == miss_idle); // strobes while busy are ignored
    assign busy = (state == miss_wait);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= miss_idle;
        end else begin
            case (state)
                miss_idle: begin
                    if (accept) begin
                        state <= miss_wait;
                    end
                end
                miss_wait: begin
                    if (fill_finish) begin
                        state <= miss_idle; // the response goes out on this same edge
                    end
                end
                default: state <= miss_idle;
            endcase
        end
    end

    // fields stay frozen for the whole refill so buffer and commit agree on the request
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= miss_addr;
            req_op <= miss_op;
            req_width <= miss_width;
            req_uncached <= miss_uncached;
            req_store_data <= miss_store_data;
        end
    end

endmodule

// File: source/return_buffer.sv
// collects the returned memory beats into one cache line and merges the store data of a write miss
module return_buffer
    import refill_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [31:0]          req_addr,
    input  op_kind               req_op,
    input  store_width           req_width,
    input  logic                 req_uncached,
    input  logic [31:0]          req_store_data,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  logic [31:0]          ret_data,
    output logic [line_bits-1:0] line_out,
    output logic                 fill_finish
);

    localparam int count_bits = $clog2(line_words);

    logic [count_bits-1:0] count;
    logic                  last_seen;
    logic                  last_edge;
    logic                  merge_hit;
    logic [31:0]           beat_word;

    // ret_last may stay high for several cycles, only the first one ends the fill
    assign last_edge = ret_valid && ret_last && !last_seen;

    assign merge_hit = !req_uncached && (req_op == op_write)
                       && (count == req_addr[count_bits+1:2]);

    always_comb begin
        beat_word = ret_data;
        if (merge_hit) begin
            case (req_width)
                width_byte: beat_word[req_addr[1:0]*8 +: 8] = req_store_data[7:0];
                width_half: beat_word[req_addr[1]*16 +: 16] = req_store_data[15:0];
                width_word: beat_word = req_store_data;
                default: beat_word = ret_data; // unknown width leaves the beat untouched
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            last_seen <= 1'b0;
            fill_finish <= 1'b0;
        end else begin
            last_seen <= ret_valid && ret_last;
            fill_finish <= last_edge;
            if (last_edge) begin
                count <= '0;
            end else if (ret_valid) begin
                count <= count + 1'b1;
            end
        end
    end

    // beats enter at the top so beat 0 ends up in word 0 after sixteen shifts
    always_ff @(posedge clk) begin
        if (ret_valid) begin
            if (req_uncached) begin
                line_out <= {{(line_bits-32){1'b0}}, ret_data};
            end else begin
                line_out <= {beat_word, line_out[line_bits-1:32]};
            end
        end
    end

endmodule

// File: source/refill_commit.sv
// line array that stores each finished cached refill and returns the requested word to the CPU
module refill_commit
    import refill_pkg::*;
#(
    parameter int set_count = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         fill_finish,
    input  logic [line_bits-1:0]         line_out,
    input  logic [31:0]                  req_addr,
    input  op_kind                       req_op,
    input  logic                         req_uncached,
    input  logic [$clog2(set_count)-1:0] line_index,
    output logic                         load_valid,
    output logic [31:0]                  load_data,
    output logic [line_bits-1:0]         line_data
);

    localparam int index_bits = $clog2(set_count);

    logic [line_bits-1:0]  lines [set_count];
    logic [index_bits-1:0] fill_index;
    logic [3:0]            word_off;
    logic                  line_write;
    logic [31:0]           resp_word;

    assign fill_index = req_addr[6 +: index_bits];
    assign word_off = req_uncached ? 4'd0 : req_addr[5:2]; // an uncached beat sits in word 0
    assign line_write = fill_finish && !req_uncached;
    assign resp_word = line_out[word_off*32 +: 32]; // a store's word already holds the merge

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < set_count; i++) begin
                lines[i] <= '0;
            end
        end else if (line_write) begin
            lines[fill_index] <= line_out;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= fill_finish;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_finish) begin
            load_data <= resp_word;
        end
    end

    assign line_data = lines[line_index];

endmodule

// File: source/cache_refill.sv
// top of the data cache refill path, wiring the miss register, return buffer and commit block
module cache_refill
    import refill_pkg::*;
#(
    parameter int set_count = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         miss_valid,
    input  logic [31:0]                  miss_addr,
    input  op_kind                       miss_op,
    input  store_width                   miss_width,
    input  logic                         miss_uncached,
    input  logic [31:0]                  miss_store_data,
    input  logic                         ret_valid,
    input  logic                         ret_last,
    input  logic [31:0]                  ret_data,
    input  logic [$clog2(set_count)-1:0] line_index,
    output logic                         busy,
    output logic                         load_valid,
    output logic [31:0]                  load_data,
    output logic [line_bits-1:0]         line_data
);

    logic [31:0]          req_addr;
    op_kind               req_op;
    store_width           req_width;
    logic                 req_uncached;
    logic [31:0]          req_store_data;
    logic [line_bits-1:0] line_out;
    logic                 fill_finish;

    miss_request_reg miss_request_reg_i (
        .clk             (clk),
        .reset           (reset),
        .miss_valid      (miss_valid),
        .miss_addr       (miss_addr),
        .miss_op         (miss_op),
        .miss_width      (miss_width),
        .miss_uncached   (miss_uncached),
        .miss_store_data (miss_store_data),
        .fill_finish     (fill_finish),
        .req_addr        (req_addr),
        .req_op          (req_op),
        .req_width       (req_width),
        .req_uncached    (req_uncached),
        .req_store_data  (req_store_data),
        .busy            (busy)
    );

    return_buffer return_buffer_i (
        .clk            (clk),
        .reset          (reset),
        .req_addr       (req_addr),
        .req_op         (req_op),
        .req_width      (req_width),
        .req_uncached   (req_uncached),
        .req_store_data (req_store_data),
        .ret_valid      (ret_valid),
        .ret_last       (ret_last),
        .ret_data       (ret_data),
        .line_out       (line_out),
        .fill_finish    (fill_finish)
    );

    refill_commit #(
        .set_count (set_count)
    ) refill_commit_i (
        .clk          (clk),
        .reset        (reset),
        .fill_finish  (fill_finish),
        .line_out     (line_out),
        .req_addr     (req_addr),
        .req_op       (req_op),
        .req_uncached (req_uncached),
        .line_index   (line_index),
        .load_valid   (load_valid),
        .load_data    (load_data),
        .line_data    (line_data)
    );

endmodule

// File: verification/cache_refill_assertions.sv
// concurrent checks on the refill handshake, bound into every miss register instance
module cache_refill_assertions (
    input logic clk,
    input logic reset,
    input logic fill_finish,
    input logic busy
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0; // read by the testbench at the end of the run

    // fill_finish comes from the return buffer and must be a single-cycle pulse
    finish_single_cycle: assert property (@(posedge clk) disable iff (reset)
        fill_finish |=> !fill_finish)
    else begin
        fail_count++;
        $error("fill_finish stayed high for two cycles");
    end

    finish_while_busy: assert property (@(posedge clk) disable iff (reset)
        fill_finish |-> busy)
    else begin
        fail_count++;
        $error("fill_finish arrived without an outstanding miss");
    end

    idle_after_reset: assert property (@(posedge clk) reset |=> !busy)
    else begin
        fail_count++;
        $error("busy was high in the cycle after reset");
    end

endmodule

bind miss_request_reg cache_refill_assertions cache_refill_assertions_i (
    .clk         (clk),
    .reset       (reset),
    .fill_finish (fill_finish),
    .busy        (busy)
);

// File: verification/cache_refill_tb.sv
// testbench for the cache refill path, plays the memory side and checks every load response
module cache_refill_tb
    import refill_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int set_count = 8;
    localparam int index_bits = $clog2(set_count);
    localparam int max_gap = 3; // longest run of idle cycles before a beat
    localparam int random_misses = 24;
    localparam int miss_total = 1 + 3 + 6 + 2 + random_misses;
    localparam int cycle_limit = miss_total * (line_words * (max_gap + 1) + 8) + 16;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  miss_valid;
    logic [31:0]           miss_addr;
    op_kind                miss_op;
    store_width            miss_width;
    logic                  miss_uncached;
    logic [31:0]           miss_store_data;
    logic                  ret_valid;
    logic                  ret_last;
    logic [31:0]           ret_data;
    logic [index_bits-1:0] line_index;
    logic                  busy;
    logic                  load_valid;
    logic [31:0]           load_data;
    logic [line_bits-1:0]  line_data;

    int seed = 59934;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int miss_count = 0;
    int response_count = 0;
    int cycle_count = 0;

    logic [line_bits-1:0] model_lines [set_count]; // what the line array should hold
    logic [31:0]          exp_word_q [$];
    logic [line_bits-1:0] exp_line_q [$];

    cache_refill #(
        .set_count (set_count)
    ) cache_refill_i (
        .clk             (clk),
        .reset           (reset),
        .miss_valid      (miss_valid),
        .miss_addr       (miss_addr),
        .miss_op         (miss_op),
        .miss_width      (miss_width),
        .miss_uncached   (miss_uncached),
        .miss_store_data (miss_store_data),
        .ret_valid       (ret_valid),
        .ret_last        (ret_last),
        .ret_data        (ret_data),
        .line_index      (line_index),
        .busy            (busy),
        .load_valid      (load_valid),
        .load_data       (load_data),
        .line_data       (line_data)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // expected line and load word after a refill, built from the beats and the store merge
    function automatic void reference_refill(
        input  logic [31:0]          addr,
        input  op_kind               op,
        input  store_width           width,
        input  logic                 uncached,
        input  logic [31:0]          store_data,
        input  logic [31:0]          beats [line_words],
        output logic [line_bits-1:0] exp_line,
        output logic [31:0]          exp_word
    );
        logic [31:0] merged;
        int          off;
        off = addr[5:2];
        exp_line = '0;
        if (uncached) begin
            exp_line[31:0] = beats[0]; // a single beat answered as is
            exp_word = beats[0];
            return;
        end
        for (int k = 0; k < line_words; k++) begin
            exp_line[k*32 +: 32] = beats[k];
        end
        if (op == op_write) begin
            merged = beats[off];
            for (int b = 0; b < 4; b++) begin
                case (width)
                    width_byte: if (b == addr[1:0]) merged[b*8 +: 8] = store_data[7:0];
                    width_half: if (b / 2 == addr[1]) merged[b*8 +: 8] = store_data[(b%2)*8 +: 8];
                    width_word: merged[b*8 +: 8] = store_data[b*8 +: 8];
                    default: ;
                endcase
            end
            exp_line[off*32 +: 32] = merged;
        end
        exp_word = exp_line[off*32 +: 32];
    endfunction

    function automatic logic [31:0] make_addr(input int idx, input int word, input int byte_off);
        return 32'h0004_0000 | (idx << 6) | (word << 2) | byte_off;
    endfunction

    task automatic check_value(input string name, input logic [line_bits-1:0] got,
                               input logic [line_bits-1:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[FAIL] %s: got %0h, expected %0h", name, got, expected);
        end
    endtask

    // issues one miss, returns its beats and waits until the request register is free again
    task automatic run_miss(input logic [31:0] addr, input op_kind op, input store_width width,
                            input logic uncached, input logic [31:0] store_data, input bit gaps);
        logic [31:0]          beats [line_words];
        logic [line_bits-1:0] ref_line;
        logic [31:0]          ref_word;
        int                   beat_total;
        int                   gap;
        int                   idx;
        idx = addr[6 +: index_bits];
        for (int k = 0; k < line_words; k++) begin
            beats[k] = $random(seed);
        end
        reference_refill(addr, op, width, uncached, store_data, beats, ref_line, ref_word);
        if (!uncached) begin
            model_lines[idx] = ref_line;
        end
        exp_word_q.push_back(ref_word);
        exp_line_q.push_back(model_lines[idx]);
        miss_count++;
        beat_total = uncached ? 1 : line_words;
        miss_valid <= 1'b1;
        miss_addr <= addr;
        miss_op <= op;
        miss_width <= width;
        miss_uncached <= uncached;
        miss_store_data <= store_data;
        line_index <= idx[index_bits-1:0];
        @(posedge clk);
        miss_valid <= 1'b0;
        for (int k = 0; k < beat_total; k++) begin
            gap = gaps ? $unsigned($random(seed)) % (max_gap + 1) : 0;
            repeat (gap) begin
                ret_valid <= 1'b0;
                ret_last <= 1'b0;
                ret_data <= $random(seed); // junk that the buffer must ignore
                @(posedge clk);
            end
            ret_valid <= 1'b1;
            ret_last <= (k == beat_total - 1);
            ret_data <= beats[k];
            @(posedge clk);
            check_value("busy", busy, 1'b1); // busy holds over every beat cycle of the refill
        end
        ret_valid <= 1'b0;
        ret_last <= 1'b0;
        do begin
            @(posedge clk);
        end while (busy);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        while (exp_word_q.size() != 0) begin
            @(posedge clk);
        end
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
    endtask

    // responses are sampled mid-cycle, when load_valid and line_data are settled
    initial begin
        logic [31:0]          exp_word;
        logic [line_bits-1:0] exp_line;
        forever begin
            @(negedge clk);
            if (!reset && load_valid) begin
                if (exp_word_q.size() == 0) begin
                    error_count++;
                    $display("load_valid was raised with no miss outstanding");
                end else begin
                    exp_word = exp_word_q.pop_front();
                    exp_line = exp_line_q.pop_front();
                    check_value("load_data", load_data, exp_word);
                    check_value("line_data", line_data, exp_line);
                    response_count++;
                end
            end
        end
    end

    initial begin
        int          errors_before;
        logic [31:0] rand_bits;
        store_width  width;
        reset = 1'b1;
        miss_valid = 1'b0;
        miss_addr = '0;
        miss_op = op_read;
        miss_width = width_word;
        miss_uncached = 1'b0;
        miss_store_data = '0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        line_index = '0;
        for (int i = 0; i < set_count; i++) begin
            model_lines[i] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        errors_before = error_count;
        run_miss(make_addr(4, 9, 0), op_read, width_word, 1'b0, 32'h0, 1'b0);
        finish_test("cached read refill", errors_before);

        errors_before = error_count;
        run_miss(make_addr(0, 0, 0), op_write, width_word, 1'b0, 32'hdead_beef, 1'b0);
        run_miss(make_addr(1, 7, 0), op_write, width_word, 1'b0, 32'h1234_5678, 1'b0);
        run_miss(make_addr(2, 15, 0), op_write, width_word, 1'b0, 32'hcafe_f00d, 1'b0);
        finish_test("cached word stores", errors_before);

        errors_before = error_count;
        for (int b = 0; b < 4; b++) begin
            run_miss(make_addr(b + 5 - (b == 0 ? 2 : 0), b + 3, b), op_write, width_byte,
                     1'b0, $random(seed), 1'b0);
        end
        run_miss(make_addr(1, 11, 0), op_write, width_half, 1'b0, $random(seed), 1'b0);
        run_miss(make_addr(2, 12, 2), op_write, width_half, 1'b0, $random(seed), 1'b0);
        finish_test("cached byte and half stores", errors_before);

        errors_before = error_count;
        run_miss(make_addr(4, 5, 0), op_read, width_word, 1'b1, 32'h0, 1'b0);
        run_miss(make_addr(4, 2, 1), op_write, width_byte, 1'b1, 32'h0000_00a5, 1'b0);
        finish_test("uncached read and write", errors_before);

        errors_before = error_count;
        for (int n = 0; n < random_misses; n++) begin
            rand_bits = $random(seed);
            case (rand_bits[4:3])
                2'd0: width = width_byte;
                2'd1: width = width_half;
                2'd2: width = width_word;
                default: width = store_width'(rand_bits[8:5]); // may be an unused code
            endcase
            run_miss($random(seed), op_kind'(rand_bits[0]), width, rand_bits[2:1] == 2'b00,
                     $random(seed), 1'b1);
        end
        finish_test("random gaps, back-to-back misses", errors_before);

        if (response_count != miss_count) begin
            error_count++;
            $display("%0d misses were issued but %0d responses arrived",
                     miss_count, response_count);
        end
        error_count += cache_refill_i.miss_request_reg_i.cache_refill_assertions_i.fail_count;
        $display("tests %0d, misses %0d, checks %0d, errors %0d",
                 test_count, miss_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: cache_refill.f
source/refill_pkg.sv
source/miss_request_reg.sv
source/return_buffer.sv
source/refill_commit.sv
source/cache_refill.sv
verification/cache_refill_assertions.sv
verification/cache_refill_tb.sv

// File: Bender.yml
package:
  name: cache_refill

sources:
  - files:
      - source/refill_pkg.sv
      - source/miss_request_reg.sv
      - source/return_buffer.sv
      - source/refill_commit.sv
      - source/cache_refill.sv
  - target: test
    files:
      - verification/cache_refill_assertions.sv
      - verification/cache_refill_tb.sv
